// File: Makefile
# Verilator flow for the drum grid simulation

VERILATOR ?= verilator
TOP       ?= drumTb
SEED      ?= 65
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR=$(VERILATOR) TOP=$(TOP) SEED=$(SEED) VFLAGS='$(VFLAGS)'"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GseedInit=$(SEED) \
	  -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 2
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Reset drops on a falling edge like every other DUT input
  initial
  begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: bench/drumTb.sv
`timescale 1ns/1ns
`default_nettype none

module drumTb #(
  parameter int seedInit = 65
);
  import drumPkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int CENTRE_STEPS = 20;
  localparam int CORNER_STEPS = 20;
  localparam int RANDOM_RUNS  = 8;
  localparam int RANDOM_STEPS = 16;
  localparam int BUSY_STEPS   = 12;
  // Every planned step of every run, sizes the watchdog
  localparam int TOTAL_STEPS  = 3 * CENTRE_STEPS + CORNER_STEPS
                              + RANDOM_RUNS * RANDOM_STEPS + BUSY_STEPS;
  localparam int WATCHDOG_CYCLES = 3 * TOTAL_STEPS + 200;

  logic                       clk;
  logic                       reset;
  logic                       start;
  logic [STEP_W-1:0]          steps;
  logic [COORD_W-1:0]         strikeX;
  logic [COORD_W-1:0]         strikeY;
  logic signed [SAMPLE_W-1:0] strikeAmp;
  logic signed [SAMPLE_W-1:0] eta;
  logic [TSEL_W-1:0]          tensionSel;
  logic [COORD_W-1:0]         probeX;
  logic [COORD_W-1:0]         probeY;
  logic                       busy;
  logic                       stepDone;
  logic signed [SAMPLE_W-1:0] probe;

  // Reference model state, indexed [x][y] like the grid
  int uModel     [GRID_N][GRID_N];
  int uPrevModel [GRID_N][GRID_N];
  int modelRho;
  int modelOme;
  int modelPx;
  int modelPy;
  int expectedSteps = 0;
  int doneCount     = 0;
  int valueErrors   = 0;
  int otherErrors   = 0;
  int checkCount    = 0;
  int tensionList [3] = '{0, 3, 7};
  integer seed;

  clockGen #(
    .periodNs    (CLK_PERIOD),
    .resetCycles (2)
  ) clocks (
    .clk   (clk),
    .reset (reset)
  );

  drumTop DUT (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .steps      (steps),
    .strikeX    (strikeX),
    .strikeY    (strikeY),
    .strikeAmp  (strikeAmp),
    .eta        (eta),
    .tensionSel (tensionSel),
    .probeX     (probeX),
    .probeY     (probeY),
    .busy       (busy),
    .stepDone   (stepDone),
    .probe      (probe)
  );

  // Keep the low 18 bits as a signed sample
  function automatic int wrapSample(input longint v);
    longint w;
    w = v & 64'h3FFFF;
    if (w >= 64'h20000)
      w = w - 64'h40000;
    return int'(w);
  endfunction

  // Q2.16 product, floored then wrapped
  function automatic int mulFloor(input int a, input int b);
    longint p;
    p = longint'(a) * longint'(b);
    return wrapSample(p >>> FRAC_W);
  endfunction

  // Clamped rim reads zero
  function automatic int cellValue(input int x, input int y);
    if (x < 0 || y < 0 || x >= GRID_N || y >= GRID_N)
      return 0;
    return uModel[x][y];
  endfunction

  // One damped wave step over the whole model grid
  function automatic void stepModel();
    int nextU [GRID_N][GRID_N];
    int lap;
    int dampLap;
    for (int x = 0; x < GRID_N; x++)
    begin
      for (int y = 0; y < GRID_N; y++)
      begin
        lap = wrapSample(longint'(cellValue(x, y - 1)) + cellValue(x, y + 1)
                         + cellValue(x + 1, y) + cellValue(x - 1, y) - 4 * uModel[x][y]);
        dampLap = mulFloor(modelOme, mulFloor(modelRho, lap));
        nextU[x][y] = wrapSample(longint'(dampLap) + 2 * uModel[x][y]
                                 - mulFloor(modelOme, uPrevModel[x][y]));
      end
    end
    uPrevModel = uModel;
    uModel = nextU;
  endfunction

  task automatic checkValue(input string name, input int got, input int expected);
    checkCount++;
    if (got != expected)
    begin
      valueErrors++;
      $display("ERROR %0t: %s expected %0d got %0d", $time, name, expected, got);
    end
  endtask

  task automatic waitBusy(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (busy !== level && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (busy !== level)
    begin
      otherErrors++;
      $display("ERROR %0t: busy did not go to %0d within %0d cycles", $time, level, limit);
    end
  endtask

  // Strike once, run nSteps, optionally pulse start again mid-run
  task automatic runDrum(input int nSteps, input int sx, input int sy, input int amp,
                         input int etaVal, input int tsel, input int px, input int py,
                         input bit pokeStart);
    for (int x = 0; x < GRID_N; x++)
    begin
      for (int y = 0; y < GRID_N; y++)
      begin
        uModel[x][y] = 0;
        uPrevModel[x][y] = 0;
      end
    end
    uModel[sx][sy] = amp;
    uPrevModel[sx][sy] = amp;
    modelRho = 2048 * (tsel + 1);
    modelOme = wrapSample(longint'(1 << FRAC_W) - etaVal);
    modelPx = px;
    modelPy = py;
    expectedSteps = nSteps;
    doneCount = 0;

    @(negedge clk);
    steps      = STEP_W'(nSteps);
    strikeX    = COORD_W'(sx);
    strikeY    = COORD_W'(sy);
    strikeAmp  = SAMPLE_W'(amp);
    eta        = SAMPLE_W'(etaVal);
    tensionSel = TSEL_W'(tsel);
    probeX     = COORD_W'(px);
    probeY     = COORD_W'(py);
    start      = 1'b1;
    @(negedge clk);
    start = 1'b0;
    waitBusy(1'b1, 4);

    if (pokeStart)
    begin
      // New settings that must not take effect
      repeat (5) @(negedge clk);
      steps      = STEP_W'(nSteps + 7);
      strikeAmp  = -strikeAmp;
      tensionSel = ~tensionSel;
      start      = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end

    waitBusy(1'b0, 3 * nSteps + 8);
    // Room for the last probe compare
    repeat (2) @(negedge clk);
    checkValue("stepDone count", doneCount, nSteps);
  endtask

  // Compare process, one model step per stepDone
  initial
  begin : compareProc
    int expected;
    forever
    begin
      @(negedge clk);
      if (!reset && stepDone)
      begin
        stepModel();
        doneCount++;
        if (doneCount > expectedSteps)
        begin
          otherErrors++;
          $display("ERROR %0t: stepDone pulsed more often than the requested steps", $time);
        end
        if (doneCount == expectedSteps && busy)
        begin
          otherErrors++;
          $display("ERROR %0t: busy still high at the final stepDone", $time);
        end
        if (doneCount < expectedSteps && !busy)
        begin
          otherErrors++;
          $display("ERROR %0t: busy dropped before the last step", $time);
        end
        @(negedge clk);
        if (stepDone)
        begin
          otherErrors++;
          $display("ERROR %0t: stepDone lasted more than one cycle", $time);
        end
        expected = uModel[modelPx][modelPy];
        checkValue("probe", int'(probe), expected);
      end
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks %0d, value errors %0d, other errors %0d",
             checkCount, valueErrors, otherErrors);
    $display("Verification failed");
    $finish;
  end

  initial
  begin : mainProc
    int sx;
    int sy;
    int amp;
    int etaVal;
    int tsel;
    int px;
    int py;
    seed       = seedInit;
    start      = 1'b0;
    steps      = '0;
    strikeX    = '0;
    strikeY    = '0;
    strikeAmp  = '0;
    eta        = '0;
    tensionSel = '0;
    probeX     = '0;
    probeY     = '0;

    wait (!reset);
    @(negedge clk);
    // Quiet outputs after reset
    checkValue("busy", int'(busy), 0);
    checkValue("stepDone", int'(stepDone), 0);
    checkValue("probe", int'(probe), 0);

    // Centre strike at three tensions, probed at the strike
    for (int t = 0; t < 3; t++)
      runDrum(CENTRE_STEPS, 1, 2, 32768, 655, tensionList[t], 1, 2, 1'b0);

    // Lossless corner strike seen from the far corner
    runDrum(CORNER_STEPS, 0, 0, 32768, 0, 5, 3, 3, 1'b0);

    for (int r = 0; r < RANDOM_RUNS; r++)
    begin
      sx     = $random(seed) & 3;
      sy     = $random(seed) & 3;
      amp    = $random(seed) & 32'h3FFF;
      etaVal = $random(seed) & 32'h0FFF;
      tsel   = $random(seed) & 7;
      px     = $random(seed) & 3;
      py     = $random(seed) & 3;
      if (amp == 0)
        amp = 1;
      runDrum(RANDOM_STEPS, sx, sy, amp, etaVal, tsel, px, py, 1'b0);
    end

    // Second start while busy
    runDrum(BUSY_STEPS, 2, 2, 24000, 300, 2, 0, 1, 1'b1);

    // Zero steps, strike only
    runDrum(0, 3, 0, 20000, 0, 4, 3, 0, 1'b0);

    $display("Checks %0d, value errors %0d, other errors %0d",
             checkCount, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hw/drumPkg.sv
hw/nodeCtrlIf.sv
hw/drumSequencer.sv
hw/gridNode.sv
hw/drumGrid.sv
hw/drumTop.sv
bench/clockGen.sv
bench/drumTb.sv

// File: hw/drumGrid.sv
`timescale 1ns/1ns
`default_nettype none

module drumGrid (
  input  logic                                clk,
  input  logic                                reset,
  nodeCtrlIf.node                             ctrl,
  input  logic [drumPkg::COORD_W-1:0]         probeX,
  input  logic [drumPkg::COORD_W-1:0]         probeY,
  output logic signed [drumPkg::SAMPLE_W-1:0] probe
);
  import drumPkg::*;

  // Indexed [x][y]; north is y-1, west is x-1
  logic signed [SAMPLE_W-1:0] uGrid [GRID_N][GRID_N];
  logic signed [SAMPLE_W-1:0] nbrN  [GRID_N][GRID_N];
  logic signed [SAMPLE_W-1:0] nbrS  [GRID_N][GRID_N];
  logic signed [SAMPLE_W-1:0] nbrE  [GRID_N][GRID_N];
  logic signed [SAMPLE_W-1:0] nbrW  [GRID_N][GRID_N];
  logic                       updateDly;

  for (genvar gx = 0; gx < GRID_N; gx++)
  begin : gCol
    for (genvar gy = 0; gy < GRID_N; gy++)
    begin : gRow
      // Clamped rim, missing neighbours read zero
      if (gy == 0)
      begin : gNorthRim
        assign nbrN[gx][gy] = '0;
      end
      else
      begin : gNorth
        assign nbrN[gx][gy] = uGrid[gx][gy-1];
      end

      if (gy == GRID_N - 1)
      begin : gSouthRim
        assign nbrS[gx][gy] = '0;
      end
      else
      begin : gSouth
        assign nbrS[gx][gy] = uGrid[gx][gy+1];
      end

      if (gx == GRID_N - 1)
      begin : gEastRim
        assign nbrE[gx][gy] = '0;
      end
      else
      begin : gEast
        assign nbrE[gx][gy] = uGrid[gx+1][gy];
      end

      if (gx == 0)
      begin : gWestRim
        assign nbrW[gx][gy] = '0;
      end
      else
      begin : gWest
        assign nbrW[gx][gy] = uGrid[gx-1][gy];
      end

      gridNode #(
        .xId(gx),
        .yId(gy)
      ) node (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .uNorth (nbrN[gx][gy]),
        .uSouth (nbrS[gx][gy]),
        .uEast  (nbrE[gx][gy]),
        .uWest  (nbrW[gx][gy]),
        .u      (uGrid[gx][gy])
      );
    end
  end

  // Sample the probe once the new displacements have settled
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      updateDly <= 1'b0;
      probe     <= '0;
    end
    else
    begin
      updateDly <= ctrl.update;
      if (updateDly)
        probe <= uGrid[probeX][probeY];
    end
  end

endmodule

`default_nettype wire

// File: hw/drumPkg.sv
`default_nettype none

package drumPkg;

  // Grid geometry
  localparam int GRID_N  = 4;
  localparam int COORD_W = 2;

  // Q2.16 fixed point: 2 integer bits (sign included), 16 fraction bits
  localparam int SAMPLE_W = 18;
  localparam int FRAC_W   = 16;

  // 1.0 in Q2.16
  localparam logic signed [SAMPLE_W-1:0] ONE_Q = 18'sd65536;

  // Run length counter width
  localparam int STEP_W = 8;

  // Tension select width and table
  localparam int TSEL_W = 3;

  // rho = 2048 * (index + 1), i.e. 1/32 steps up to 0.25
  localparam logic [SAMPLE_W-1:0] RHO_TABLE [0:7] = '{
    18'd2048,
    18'd4096,
    18'd6144,
    18'd8192,
    18'd10240,
    18'd12288,
    18'd14336,
    18'd16384
  };

  // Sequencer state codes
  localparam int STATE_W = 3;
  localparam logic [STATE_W-1:0] ST_IDLE   = 3'd0;
  localparam logic [STATE_W-1:0] ST_CLEAR  = 3'd1;
  localparam logic [STATE_W-1:0] ST_MUL0   = 3'd2;
  localparam logic [STATE_W-1:0] ST_MUL1   = 3'd3;
  localparam logic [STATE_W-1:0] ST_UPDATE = 3'd4;

endpackage

`default_nettype wire

// File: hw/drumSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module drumSequencer (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 start,
  input  logic [drumPkg::STEP_W-1:0]           steps,
  input  logic [drumPkg::COORD_W-1:0]          strikeX,
  input  logic [drumPkg::COORD_W-1:0]          strikeY,
  input  logic signed [drumPkg::SAMPLE_W-1:0]  strikeAmp,
  input  logic signed [drumPkg::SAMPLE_W-1:0]  eta,
  input  logic [drumPkg::TSEL_W-1:0]           tensionSel,
  nodeCtrlIf.master                            ctrl,
  output logic                                 busy,
  output logic                                 stepDone
);
  import drumPkg::*;

  logic [STATE_W-1:0] state;
  logic [STEP_W-1:0]  stepsLeft;
  logic               accept;

  // Start only counts in idle once the previous run has dropped busy
  assign accept = (state == ST_IDLE) && !busy && start;

  // Run settings captured at start and held for the whole run
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      ctrl.rho         <= RHO_TABLE[tensionSel];
      ctrl.oneMinusEta <= ONE_Q - eta;
      ctrl.strikeX     <= strikeX;
      ctrl.strikeY     <= strikeY;
      ctrl.strikeAmp   <= strikeAmp;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= ST_IDLE;
      stepsLeft   <= '0;
      busy        <= 1'b0;
      stepDone    <= 1'b0;
      ctrl.clear  <= 1'b0;
      ctrl.strike <= 1'b0;
      ctrl.mul0   <= 1'b0;
      ctrl.mul1   <= 1'b0;
      ctrl.update <= 1'b0;
    end
    else
    begin
      // Strobes are single-cycle unless a state below raises them
      ctrl.clear  <= 1'b0;
      ctrl.strike <= 1'b0;
      ctrl.mul0   <= 1'b0;
      ctrl.mul1   <= 1'b0;
      ctrl.update <= 1'b0;
      // Step result is visible one cycle after the update strobe
      stepDone    <= ctrl.update;

      case (state)
        ST_IDLE:
        begin
          busy <= 1'b0;
          if (accept)
          begin
            stepsLeft <= steps;
            state     <= ST_CLEAR;
          end
        end
        ST_CLEAR:
        begin
          busy        <= 1'b1;
          ctrl.clear  <= 1'b1;
          ctrl.strike <= 1'b1;
          state       <= (stepsLeft == '0) ? ST_IDLE : ST_MUL0;
        end
        ST_MUL0:
        begin
          ctrl.mul0 <= 1'b1;
          state     <= ST_MUL1;
        end
        ST_MUL1:
        begin
          ctrl.mul1 <= 1'b1;
          state     <= ST_UPDATE;
        end
        ST_UPDATE:
        begin
          ctrl.update <= 1'b1;
          stepsLeft   <= stepsLeft - 1'b1;
          // Last step returns to idle, where busy drops with stepDone
          state       <= (stepsLeft == STEP_W'(1)) ? ST_IDLE : ST_MUL0;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/drumTop.sv
`timescale 1ns/1ns
`default_nettype none

module drumTop (
  input  logic                                clk,
  input  logic                                reset,

  // Run control
  input  logic                                start,
  input  logic [drumPkg::STEP_W-1:0]          steps,

  // Strike point and amplitude
  input  logic [drumPkg::COORD_W-1:0]         strikeX,
  input  logic [drumPkg::COORD_W-1:0]         strikeY,
  input  logic signed [drumPkg::SAMPLE_W-1:0] strikeAmp,

  // Membrane settings
  input  logic signed [drumPkg::SAMPLE_W-1:0] eta,
  input  logic [drumPkg::TSEL_W-1:0]          tensionSel,

  // Probe selection
  input  logic [drumPkg::COORD_W-1:0]         probeX,
  input  logic [drumPkg::COORD_W-1:0]         probeY,

  // Status and result
  output logic                                busy,
  output logic                                stepDone,
  output logic signed [drumPkg::SAMPLE_W-1:0] probe
);

  nodeCtrlIf ctrlBus ();

  drumSequencer sequencer (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .steps      (steps),
    .strikeX    (strikeX),
    .strikeY    (strikeY),
    .strikeAmp  (strikeAmp),
    .eta        (eta),
    .tensionSel (tensionSel),
    .ctrl       (ctrlBus.master),
    .busy       (busy),
    .stepDone   (stepDone)
  );

  // All nodes run in lockstep off the shared strobes
  drumGrid grid (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrlBus.node),
    .probeX (probeX),
    .probeY (probeY),
    .probe  (probe)
  );

endmodule

`default_nettype wire

// File: hw/gridNode.sv
`timescale 1ns/1ns
`default_nettype none

module gridNode #(
  parameter int xId = 0,
  parameter int yId = 0
) (
  input  logic                                clk,
  input  logic                                reset,
  nodeCtrlIf.node                             ctrl,
  input  logic signed [drumPkg::SAMPLE_W-1:0] uNorth,
  input  logic signed [drumPkg::SAMPLE_W-1:0] uSouth,
  input  logic signed [drumPkg::SAMPLE_W-1:0] uEast,
  input  logic signed [drumPkg::SAMPLE_W-1:0] uWest,
  output logic signed [drumPkg::SAMPLE_W-1:0] u
);
  import drumPkg::*;

  logic signed [SAMPLE_W-1:0]   uPrev;
  logic signed [SAMPLE_W-1:0]   rhoLap;
  logic signed [SAMPLE_W-1:0]   dampLap;
  logic signed [SAMPLE_W-1:0]   lap;
  logic signed [SAMPLE_W-1:0]   mulA;
  logic signed [SAMPLE_W-1:0]   mulB;
  logic signed [2*SAMPLE_W-1:0] product;
  logic signed [2*SAMPLE_W-1:0] productShift;
  logic signed [SAMPLE_W-1:0]   mulOut;
  logic                         struck;

  // Discrete Laplacian, wraps at 18 bits
  assign lap = uNorth + uSouth + uEast + uWest - (u <<< 2);

  // One multiplier shared by the three phases
  //   mul0:   rho * lap
  //   mul1:   (1 - eta) * rhoLap
  //   update: (1 - eta) * uPrev
  always_comb
  begin
    mulA = ctrl.mul0 ? ctrl.rho : ctrl.oneMinusEta;
    if (ctrl.mul0)
      mulB = lap;
    else if (ctrl.mul1)
      mulB = rhoLap;
    else
      mulB = uPrev;
  end

  assign product      = mulA * mulB;
  // Arithmetic shift floors toward minus infinity
  assign productShift = product >>> FRAC_W;
  assign mulOut       = productShift[SAMPLE_W-1:0];

  assign struck = ctrl.strike &&
                  (ctrl.strikeX == COORD_W'(xId)) &&
                  (ctrl.strikeY == COORD_W'(yId));

  // Intermediate products
  always_ff @(posedge clk)
  begin
    if (ctrl.mul0)
      rhoLap <= mulOut;
    if (ctrl.mul1)
      dampLap <= mulOut;
  end

  // Displacement state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      u     <= '0;
      uPrev <= '0;
    end
    else if (ctrl.clear)
    begin
      // Strike seeds both time levels so the node starts at rest
      u     <= struck ? ctrl.strikeAmp : '0;
      uPrev <= struck ? ctrl.strikeAmp : '0;
    end
    else if (ctrl.update)
    begin
      u     <= dampLap + (u <<< 1) - mulOut;
      uPrev <= u;
    end
  end

endmodule

`default_nettype wire

// File: hw/nodeCtrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface nodeCtrlIf;
  import drumPkg::*;

  // Run setup strobes
  logic                       clear;
  logic                       strike;
  logic [COORD_W-1:0]         strikeX;
  logic [COORD_W-1:0]         strikeY;
  logic signed [SAMPLE_W-1:0] strikeAmp;

  // Per-step phase strobes
  logic mul0;
  logic mul1;
  logic update;

  // Coefficients shared by every node, stable during a run
  logic signed [SAMPLE_W-1:0] rho;
  logic signed [SAMPLE_W-1:0] oneMinusEta;

  modport master (output clear, strike, strikeX, strikeY, strikeAmp,
                  mul0, mul1, update, rho, oneMinusEta);
  modport node (input clear, strike, strikeX, strikeY, strikeAmp,
                mul0, mul1, update, rho, oneMinusEta);

endinterface

`default_nettype wire
